// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module dmaTb -o dmaSim
	@out=$$(./obj_dir/dmaSim); \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// ==== dv/dmaTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaTb;
  import dmaPkg::*;

  localparam int NumChannels = 4;
  localparam logic [7:0] NoAbort = 8'hFF;

  typedef struct packed {
    logic [1:0]  chan;
    xferTypeT    xType;
    logic        dec;
    logic [15:0] start;
    logic [15:0] count;
    logic [7:0]  abortAt; // Transfer index aborted in S0
  } rowT;

  localparam int NumRows = 5;
  // chan, type, decrement, start address, count, abort index
  localparam rowT Rows [NumRows] = '{
    '{2'd0, writeXfer,   1'b0, 16'h1000, 16'd3, NoAbort},
    '{2'd2, readXfer,    1'b1, 16'h20F1, 16'd2, NoAbort},
    '{2'd3, verifyXfer,  1'b0, 16'hFFFE, 16'd2, NoAbort}, // Address wraps
    '{2'd1, writeXfer,   1'b0, 16'h0400, 16'd4, 8'd2},
    '{2'd0, illegalXfer, 1'b1, 16'h0001, 16'd1, NoAbort}
  };
  localparam rowT PrioLow  = '{2'd1, writeXfer, 1'b0, 16'h0100, 16'd0, NoAbort};
  localparam rowT PrioHigh = '{2'd3, readXfer,  1'b0, 16'h0300, 16'd0, NoAbort};

  logic                   CLK;
  logic                   rstN;
  cpuPortT                cpuPort;
  logic [7:0]             cpuData;
  logic [NumChannels-1:0] dreq;
  logic                   hlda;
  logic                   eopInN;
  logic                   hrq;
  logic                   aen;
  logic                   adstb;
  logic                   eop;
  logic [NumChannels-1:0] dack;
  busStrobeT              strobes;
  logic [15:0]            addr;

  int errors;
  int checks;
  int tests;
  int adstbSeen;
  int strobeSeen;

  dmaTop #(.NumChannels(NumChannels)) u_dut (
    .CLK     (CLK),
    .rstN    (rstN),
    .cpuPort (cpuPort),
    .cpuData (cpuData),
    .dreq    (dreq),
    .hlda    (hlda),
    .eopInN  (eopInN),
    .hrq     (hrq),
    .aen     (aen),
    .adstb   (adstb),
    .eop     (eop),
    .dack    (dack),
    .strobes (strobes),
    .addr    (addr)
  );

  initial
  begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // One clock with outputs sampled before new inputs go out
  task automatic tick();
    @(posedge CLK);
    #2;
    if (adstb)
      adstbSeen++;
    if (strobes !== 4'hF)
      strobeSeen++;
  endtask

  task automatic expectEq(string name, logic [15:0] got, logic [15:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic stopOnTimeout(string what);
    $display("timeout: %s", what);
    $display("Verification failed");
    $finish;
  endtask

  task automatic cpuWrite(regSelT sel, logic [1:0] chan, logic [7:0] data);
    cpuPort.csN  = 1'b0;
    cpuPort.wrN  = 1'b0;
    cpuPort.sel  = sel;
    cpuPort.chan = chan;
    cpuPort.data = data;
    tick();
    cpuPort.csN = 1'b1;
    cpuPort.wrN = 1'b1;
  endtask

  task automatic cpuRead(regSelT sel, logic [1:0] chan, output logic [7:0] data);
    cpuPort.csN  = 1'b0;
    cpuPort.wrN  = 1'b1;
    cpuPort.sel  = sel;
    cpuPort.chan = chan;
    #1;
    data = cpuData;
    tick();
    cpuPort.csN = 1'b1;
    tick(); // Lets a status read clear
  endtask

  task automatic programRow(rowT r);
    cpuWrite(addrLo, r.chan, r.start[7:0]);
    cpuWrite(addrHi, r.chan, r.start[15:8]);
    cpuWrite(countLo, r.chan, r.count[7:0]);
    cpuWrite(countHi, r.chan, r.count[15:8]);
    cpuWrite(modeReg, r.chan, {5'b0, r.xType, r.dec});
    cpuWrite(maskClear, r.chan, 8'h00);
  endtask

  // Expected S2 strobes in memrN memwN iorN iowN order
  function automatic logic [3:0] expStrobes(xferTypeT t);
    case (t)
      writeXfer: return 4'b1001;
      readXfer:  return 4'b0110;
      default:   return 4'b1111;
    endcase
  endfunction

  function automatic logic [15:0] expAddr(rowT r, int k);
    return r.dec ? r.start - 16'(k) : r.start + 16'(k);
  endfunction

  task automatic runTransfer(rowT r, int k, output logic aborted);
    int delay;
    int n;
    logic [3:0] chanBit;
    aborted = 1'b0;
    chanBit = 4'b0001 << r.chan;
    n = 0;
    while (!hrq && n < 20)
    begin
      tick();
      n++;
    end
    if (!hrq)
      stopOnTimeout("hrq did not rise after dreq");
    if (k == int'(r.abortAt))
    begin
      eopInN = 1'b0;
      dreq[r.chan] = 1'b0;
      tick();
      expectEq("hrq after abort", 16'(hrq), 16'd0);
      expectEq("strobes after abort", 16'(strobes), 16'hF);
      eopInN = 1'b1;
      aborted = 1'b1;
    end
    else
    begin
      delay = $urandom % 6;
      repeat (delay)
      begin
        tick();
        expectEq("hrq in S0", 16'(hrq), 16'd1);
        expectEq("aen in S0", 16'(aen), 16'd0);
      end
      hlda = 1'b1;
      tick(); // S1
      expectEq("adstb", 16'(adstb), 16'd1);
      expectEq("aen", 16'(aen), 16'd1);
      expectEq("addr", addr, expAddr(r, k));
      expectEq("dack in S1", 16'(dack), 16'd0);
      tick(); // S2
      expectEq("adstb in S2", 16'(adstb), 16'd0);
      expectEq("aen in S2", 16'(aen), 16'd1);
      expectEq("strobes", 16'(strobes), 16'(expStrobes(r.xType)));
      expectEq("dack", 16'(dack), 16'(chanBit));
      expectEq("addr in S2", addr, expAddr(r, k));
      expectEq("eop in S2", 16'(eop), 16'd0);
      tick(); // S4
      expectEq("hrq in S4", 16'(hrq), 16'd1);
      expectEq("strobes in S4", 16'(strobes), 16'hF);
      expectEq("dack in S4", 16'(dack), 16'(chanBit));
      expectEq("eop", 16'(eop), 16'(k == int'(r.count)));
      hlda = 1'b0;
      tick();
      expectEq("hrq after S4", 16'(hrq), 16'd0);
    end
  endtask

  task automatic reportTest(string name, int errBefore);
    tests++;
    if (errors == errBefore)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - errBefore);
  endtask

  task automatic runRow(int idx);
    rowT r;
    logic aborted;
    logic strobing;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [7:0] stat;
    int errBefore;
    int xfers;
    r = Rows[idx];
    errBefore = errors;
    programRow(r);
    adstbSeen = 0;
    strobeSeen = 0;
    aborted = 1'b0;
    xfers = 0;
    dreq[r.chan] = 1'b1;
    for (int k = 0; k <= int'(r.count) && !aborted; k++)
    begin
      runTransfer(r, k, aborted);
      if (!aborted)
        xfers++;
    end
    strobing = (r.xType == writeXfer) || (r.xType == readXfer);
    expectEq("adstb pulses", 16'(adstbSeen), 16'(xfers));
    expectEq("strobe cycles", 16'(strobeSeen), strobing ? 16'(xfers) : 16'd0);
    if (aborted)
    begin
      cpuRead(countLo, r.chan, lo);
      cpuRead(countHi, r.chan, hi);
      expectEq("count after abort", {hi, lo}, r.count - 16'(xfers));
      cpuRead(addrLo, r.chan, lo);
      cpuRead(addrHi, r.chan, hi);
      expectEq("address after abort", {hi, lo}, expAddr(r, xfers));
      cpuWrite(maskSet, r.chan, 8'h00);
    end
    else
    begin
      cpuRead(statusReg, 2'd0, stat);
      expectEq("status tc", 16'(stat[3:0]), 16'(4'b0001 << r.chan));
      expectEq("status dreq", 16'(stat[7:4]), 16'(4'b0001 << r.chan));
      cpuRead(statusReg, 2'd0, stat);
      expectEq("status tc after read", 16'(stat[3:0]), 16'd0);
      repeat (4)
      begin
        tick();
        expectEq("hrq on masked channel", 16'(hrq), 16'd0);
      end
      dreq[r.chan] = 1'b0;
    end
    reportTest($sformatf("row %0d", idx), errBefore);
  endtask

  initial
  begin
    logic aborted;
    logic [7:0] stat;
    int errBefore;
    void'($urandom(32'h4fe6da8d));
    rstN = 1'b0;
    cpuPort = '{csN: 1'b1, wrN: 1'b1, sel: addrLo, chan: 2'd0, data: 8'h00};
    dreq = '0;
    hlda = 1'b0;
    eopInN = 1'b1;
    errors = 0;
    checks = 0;
    tests = 0;
    adstbSeen = 0;
    strobeSeen = 0;
    repeat (5) tick();
    rstN = 1'b1;

    errBefore = errors;
    tick();
    expectEq("hrq after reset", 16'(hrq), 16'd0);
    expectEq("aen after reset", 16'(aen), 16'd0);
    expectEq("adstb after reset", 16'(adstb), 16'd0);
    expectEq("dack after reset", 16'(dack), 16'd0);
    expectEq("eop after reset", 16'(eop), 16'd0);
    expectEq("strobes after reset", 16'(strobes), 16'hF);
    dreq = '1; // All channels start masked
    repeat (3)
    begin
      tick();
      expectEq("hrq with reset masks", 16'(hrq), 16'd0);
    end
    dreq = '0;
    reportTest("reset", errBefore);

    for (int i = 0; i < NumRows; i++)
      runRow(i);

    errBefore = errors;
    programRow(PrioLow);
    programRow(PrioHigh);
    dreq[1] = 1'b1;
    dreq[3] = 1'b1;
    runTransfer(PrioLow, 0, aborted);
    runTransfer(PrioHigh, 0, aborted);
    cpuRead(statusReg, 2'd0, stat);
    expectEq("status tc both", 16'(stat[3:0]), 16'b1010);
    expectEq("status dreq both", 16'(stat[7:4]), 16'b1010);
    dreq = '0;
    reportTest("priority", errBefore);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/dmaPkg.sv
src/dmaRegisters.sv
src/dmaPriority.sv
src/dmaTimingControl.sv
src/dmaTop.sv
dv/dmaTb.sv

// ==== src/dmaPkg.sv ====
`default_nettype none

package dmaPkg;

  localparam int AddrWidth = 16; // Address and count width

  // One-hot controller states without S3
  typedef enum logic [4:0] {
    stSI = 5'b00001,
    stS0 = 5'b00010,
    stS1 = 5'b00100,
    stS2 = 5'b01000,
    stS4 = 5'b10000
  } dmaStateT;

  typedef enum logic [1:0] {
    verifyXfer  = 2'b00, // No strobes
    writeXfer   = 2'b01, // I/O read, memory write
    readXfer    = 2'b10, // Memory read, I/O write
    illegalXfer = 2'b11  // Treated as verify
  } xferTypeT;

  typedef struct packed {
    xferTypeT xferType;
    logic     decrement; // Step address downwards
  } modeT;

  // CPU register selects
  typedef enum logic [3:0] {
    addrLo    = 4'h0,
    addrHi    = 4'h1,
    countLo   = 4'h2,
    countHi   = 4'h3,
    modeReg   = 4'h4,
    maskSet   = 4'h5,
    maskClear = 4'h6,
    statusReg = 4'h7
  } regSelT;

  // Active-low bus strobes
  typedef struct packed {
    logic memrN;
    logic memwN;
    logic iorN;
    logic iowN;
  } busStrobeT;

  localparam busStrobeT StrobesIdle = '{
    memrN: 1'b1,
    memwN: 1'b1,
    iorN:  1'b1,
    iowN:  1'b1
  };

  // CPU register port request
  typedef struct packed {
    logic       csN;
    logic       wrN;
    regSelT     sel;
    logic [1:0] chan; // Only used by per-channel selects
    logic [7:0] data;
  } cpuPortT;

endpackage

`default_nettype wire

// ==== src/dmaPriority.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaPriority #(
  parameter int NumChannels = 4
) (
  input  logic [NumChannels-1:0] dreq,
  input  logic [NumChannels-1:0] mask,
  output logic [NumChannels-1:0] grant
);

  logic [NumChannels-1:0] pending;
  logic                   found;

  assign pending = dreq & ~mask;

  // Fixed priority with channel 0 highest
  always_comb
  begin
    grant = '0;
    found = 1'b0;
    for (int i = 0; i < NumChannels; i++)
    begin
      if (pending[i] && !found)
      begin
        grant[i] = 1'b1;
        found    = 1'b1;
      end
    end
  end

  // Grant is a single unmasked request or nothing
  always_comb
  begin
    assert final ($onehot0(grant) && ((grant & ~pending) == '0));
  end

endmodule

`default_nettype wire

// ==== src/dmaRegisters.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaRegisters #(
  parameter int NumChannels = 4
) (
  input  logic                          CLK,
  input  logic                          rstN,
  input  dmaPkg::cpuPortT               cpuPort,
  output logic [7:0]                    cpuData,
  input  logic [NumChannels-1:0]        dreq,
  output logic [NumChannels-1:0]        mask,
  input  logic [1:0]                    activeChan,
  input  logic                          step,
  input  logic                          tcHit,
  output dmaPkg::modeT                  chanMode,
  output logic [dmaPkg::AddrWidth-1:0]  curAddr,
  output logic [dmaPkg::AddrWidth-1:0]  curCount
);
  import dmaPkg::*;

  logic [AddrWidth-1:0] baseAddr [NumChannels];
  logic [AddrWidth-1:0] baseCount [NumChannels];
  logic [AddrWidth-1:0] curAddrR [NumChannels];
  logic [AddrWidth-1:0] curCountR [NumChannels];
  modeT                 modes [NumChannels];
  logic [NumChannels-1:0] tcStatus;

  logic cpuWrite;
  logic cpuRead;
  logic chanOk;
  logic statusRd;
  logic statusRdQ;
  logic [AddrWidth-1:0] addrLoNext;
  logic [AddrWidth-1:0] addrHiNext;
  logic [AddrWidth-1:0] countLoNext;
  logic [AddrWidth-1:0] countHiNext;
  logic [AddrWidth-1:0] stepAddr;

  assign cpuWrite = !cpuPort.csN && !cpuPort.wrN;
  assign cpuRead  = !cpuPort.csN && cpuPort.wrN;
  assign chanOk   = int'(cpuPort.chan) < NumChannels;
  assign statusRd = cpuRead && (cpuPort.sel == statusReg);

  // Byte writes merge with the base copy, then load base and current
  assign addrLoNext  = {baseAddr[cpuPort.chan][AddrWidth-1:8], cpuPort.data};
  assign addrHiNext  = {cpuPort.data, baseAddr[cpuPort.chan][7:0]};
  assign countLoNext = {baseCount[cpuPort.chan][AddrWidth-1:8], cpuPort.data};
  assign countHiNext = {cpuPort.data, baseCount[cpuPort.chan][7:0]};

  assign stepAddr = modes[activeChan].decrement ? curAddrR[activeChan] - 1'b1
                                                : curAddrR[activeChan] + 1'b1;

  always_ff @(posedge CLK)
  begin
    if (cpuWrite && chanOk)
    begin
      case (cpuPort.sel)
        addrLo:
        begin
          baseAddr[cpuPort.chan] <= addrLoNext;
          curAddrR[cpuPort.chan] <= addrLoNext;
        end
        addrHi:
        begin
          baseAddr[cpuPort.chan] <= addrHiNext;
          curAddrR[cpuPort.chan] <= addrHiNext;
        end
        countLo:
        begin
          baseCount[cpuPort.chan] <= countLoNext;
          curCountR[cpuPort.chan] <= countLoNext;
        end
        countHi:
        begin
          baseCount[cpuPort.chan] <= countHiNext;
          curCountR[cpuPort.chan] <= countHiNext;
        end
        default: ;
      endcase
    end
    if (step)
    begin
      curAddrR[activeChan]  <= stepAddr;
      curCountR[activeChan] <= curCountR[activeChan] - 1'b1;
    end
  end

  always_ff @(posedge CLK or negedge rstN)
  begin
    if (!rstN)
    begin
      mask      <= '1; // All channels masked
      tcStatus  <= '0;
      statusRdQ <= 1'b0;
      for (int i = 0; i < NumChannels; i++)
        modes[i] <= '0;
    end
    else
    begin
      statusRdQ <= statusRd;
      if (statusRdQ && !statusRd)
        tcStatus <= '0; // Cleared as the status read ends
      if (cpuWrite && chanOk)
      begin
        case (cpuPort.sel)
          modeReg:   modes[cpuPort.chan] <= modeT'(cpuPort.data[2:0]);
          maskSet:   mask[cpuPort.chan] <= 1'b1;
          maskClear: mask[cpuPort.chan] <= 1'b0;
          default: ;
        endcase
      end
      if (tcHit)
      begin
        tcStatus[activeChan] <= 1'b1;
        mask[activeChan]     <= 1'b1; // No auto-init, so park the channel
      end
    end
  end

  always_comb
  begin
    cpuData = 8'h00;
    if (cpuRead)
    begin
      case (cpuPort.sel)
        addrLo:    cpuData = chanOk ? curAddrR[cpuPort.chan][7:0] : 8'h00;
        addrHi:    cpuData = chanOk ? curAddrR[cpuPort.chan][AddrWidth-1:8] : 8'h00;
        countLo:   cpuData = chanOk ? curCountR[cpuPort.chan][7:0] : 8'h00;
        countHi:   cpuData = chanOk ? curCountR[cpuPort.chan][AddrWidth-1:8] : 8'h00;
        modeReg:   cpuData = chanOk ? {5'b0, modes[cpuPort.chan]} : 8'h00;
        maskSet,
        maskClear: cpuData = {4'b0, 4'(mask)};
        statusReg: cpuData = {4'(dreq), 4'(tcStatus)};
        default:   cpuData = 8'h00;
      endcase
    end
  end

  assign chanMode = modes[activeChan];
  assign curAddr  = curAddrR[activeChan];
  assign curCount = curCountR[activeChan];

  // A step must not race a CPU load of the same channel
  assert property (@(posedge CLK) disable iff (!rstN)
    step |-> !(cpuWrite && cpuPort.chan == activeChan &&
               cpuPort.sel inside {addrLo, addrHi, countLo, countHi}));

endmodule

`default_nettype wire

// ==== src/dmaTimingControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaTimingControl #(
  parameter int NumChannels = 4
) (
  input  logic                          CLK,
  input  logic                          rstN,
  input  logic [NumChannels-1:0]        grant,
  input  logic                          cpuBusy,
  input  logic                          hlda,
  input  logic                          eopInN,
  input  dmaPkg::modeT                  chanMode,
  input  logic [dmaPkg::AddrWidth-1:0]  curAddr,
  input  logic [dmaPkg::AddrWidth-1:0]  curCount,
  output logic [1:0]                    activeChan,
  output logic                          hrq,
  output logic                          aen,
  output logic                          adstb,
  output logic                          eop,
  output logic                          step,
  output logic                          tcHit,
  output logic [NumChannels-1:0]        dack,
  output dmaPkg::busStrobeT             strobes,
  output logic [dmaPkg::AddrWidth-1:0]  addr
);
  import dmaPkg::*;

  dmaStateT   state;
  dmaStateT   nextState;
  logic [1:0] grantIdx;
  logic       startXfer;

  // Encode the one-hot grant
  always_comb
  begin
    grantIdx = 2'd0;
    for (int i = 0; i < NumChannels; i++)
    begin
      if (grant[i])
        grantIdx = 2'(i);
    end
  end

  assign startXfer = (state == stSI) && (|grant) && !cpuBusy;

  always_ff @(posedge CLK or negedge rstN)
  begin
    if (!rstN)
    begin
      state      <= stSI;
      activeChan <= 2'd0;
    end
    else
    begin
      state <= nextState;
      if (startXfer)
        activeChan <= grantIdx; // Held for the whole transfer
    end
  end

  always_comb
  begin
    nextState = state;
    unique case (state)
      stSI:
        if (startXfer)
          nextState = stS0;
      stS0:
        if (!eopInN)
          nextState = stSI; // External abort
        else if (hlda)
          nextState = stS1;
      stS1:
        nextState = !eopInN ? stSI : stS2;
      stS2:
        nextState = !eopInN ? stSI : stS4;
      stS4:
        nextState = stSI;
      default:
        nextState = stSI;
    endcase
  end

  assign hrq   = (state != stSI);
  assign aen   = (state == stS1) || (state == stS2) || (state == stS4);
  assign adstb = (state == stS1);
  assign addr  = aen ? curAddr : '0;
  assign dack  = ((state == stS2) || (state == stS4)) ? (NumChannels'(1) << activeChan) : '0;

  // Strobe pair from the transfer type in S2 only
  always_comb
  begin
    strobes = StrobesIdle;
    if (state == stS2)
    begin
      case (chanMode.xferType)
        writeXfer:
        begin
          strobes.iorN  = 1'b0;
          strobes.memwN = 1'b0;
        end
        readXfer:
        begin
          strobes.memrN = 1'b0;
          strobes.iowN  = 1'b0;
        end
        default: ; // Verify and illegal run without strobes
      endcase
    end
  end

  assign step  = (state == stS4);
  assign tcHit = step && (curCount == '0); // Count was zero before this step
  assign eop   = tcHit;

  // Never read memory and I/O together
  assert property (@(posedge CLK) disable iff (!rstN)
    !(!strobes.memrN && !strobes.iorN));

  assert property (@(posedge CLK) disable iff (!rstN)
    (strobes != StrobesIdle) |-> (state == stS2) && $past(state) == stS1);

  assert property (@(posedge CLK) disable iff (!rstN)
    ((state == stS2) || (state == stS4)) |-> $onehot(dack));

endmodule

`default_nettype wire

// ==== src/dmaTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmaTop #(
  parameter int NumChannels = 4
) (
  input  logic                          CLK,
  input  logic                          rstN,
  input  dmaPkg::cpuPortT               cpuPort,
  output logic [7:0]                    cpuData,
  input  logic [NumChannels-1:0]        dreq,
  input  logic                          hlda,
  input  logic                          eopInN,
  output logic                          hrq,
  output logic                          aen,
  output logic                          adstb,
  output logic                          eop,
  output logic [NumChannels-1:0]        dack,
  output dmaPkg::busStrobeT             strobes,
  output logic [dmaPkg::AddrWidth-1:0]  addr
);
  import dmaPkg::*;

  logic [NumChannels-1:0] mask;
  logic [NumChannels-1:0] grant;
  logic [1:0]             activeChan;
  logic                   step;
  logic                   tcHit;
  logic                   cpuBusy;
  modeT                   chanMode;
  logic [AddrWidth-1:0]   curAddr;
  logic [AddrWidth-1:0]   curCount;

  assign cpuBusy = !cpuPort.csN; // No new transfer while the CPU is selected

  dmaRegisters #(.NumChannels(NumChannels)) u_registers (
    .CLK        (CLK),
    .rstN       (rstN),
    .cpuPort    (cpuPort),
    .cpuData    (cpuData),
    .dreq       (dreq),
    .mask       (mask),
    .activeChan (activeChan),
    .step       (step),
    .tcHit      (tcHit),
    .chanMode   (chanMode),
    .curAddr    (curAddr),
    .curCount   (curCount)
  );

  dmaPriority #(.NumChannels(NumChannels)) u_priority (
    .dreq  (dreq),
    .mask  (mask),
    .grant (grant)
  );

  dmaTimingControl #(.NumChannels(NumChannels)) u_timing (
    .CLK        (CLK),
    .rstN       (rstN),
    .grant      (grant),
    .cpuBusy    (cpuBusy),
    .hlda       (hlda),
    .eopInN     (eopInN),
    .chanMode   (chanMode),
    .curAddr    (curAddr),
    .curCount   (curCount),
    .activeChan (activeChan),
    .hrq        (hrq),
    .aen        (aen),
    .adstb      (adstb),
    .eop        (eop),
    .step       (step),
    .tcHit      (tcHit),
    .dack       (dack),
    .strobes    (strobes),
    .addr       (addr)
  );

endmodule

`default_nettype wire
